// File: mem_test.f
+incdir+source
source/mem_test_pkg.sv
source/mem_tester.sv
source/test_ram.sv
source/elapsed_timer.sv
source/status_regs_axil.sv
source/mem_test_top.sv
test/tb_clock_gen.sv
test/mem_test_properties.sv
test/mem_test_tb.sv

// File: source/elapsed_timer.sv
`timescale 1ns/1ps
`include "mem_test_macros.svh"

module elapsed_timer (
    input  logic                   clk_gui,
    input  logic                   timer_reset,
    output mem_test_pkg::elapsed_t elapsed
);

    localparam int TICK_W = $clog2(`TICKS_PER_SEC);
    localparam int SMIN_W = $clog2(`SECS_PER_MIN);
    localparam logic [TICK_W-1:0] TICK_MAX = TICK_W'(`TICKS_PER_SEC - 1);
    localparam logic [SMIN_W-1:0] SMIN_MAX = SMIN_W'(`SECS_PER_MIN - 1);

    logic [TICK_W-1:0] tick_cnt_q;      // Prescaler
    logic [SMIN_W-1:0] sec_in_min_q;    // Second within the minute
    logic [15:0]       secs_q;          // Seconds since reset
    logic [15:0]       mins_q;          // BCD minutes
    logic              sec_tick;
    logic              min_tick;

    assign sec_tick = (tick_cnt_q == TICK_MAX);
    assign min_tick = sec_tick && (sec_in_min_q == SMIN_MAX);

    ////////////////////////////////////////////////////////////////////////////
    // Seconds
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            tick_cnt_q   <= '0;
            sec_in_min_q <= '0;
            secs_q       <= '0;
        end else begin
            tick_cnt_q <= sec_tick ? '0 : tick_cnt_q + 1'b1;
            if (sec_tick) begin
                secs_q       <= secs_q + 1'b1;                        // Free running
                sec_in_min_q <= min_tick ? '0 : sec_in_min_q + 1'b1;
            end
        end
    end

    // Minutes, one BCD digit at a time with ripple carry
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            mins_q <= '0;
        end else if (min_tick) begin
            if (mins_q[3:0] < 4'd9) mins_q[3:0] <= mins_q[3:0] + 1'b1;
            else begin
                mins_q[3:0] <= '0;
                if (mins_q[7:4] < 4'd9) mins_q[7:4] <= mins_q[7:4] + 1'b1;
                else begin
                    mins_q[7:4] <= '0;
                    if (mins_q[11:8] < 4'd9) mins_q[11:8] <= mins_q[11:8] + 1'b1;
                    else begin
                        mins_q[11:8] <= '0;
                        if (mins_q[15:12] < 4'd9) mins_q[15:12] <= mins_q[15:12] + 1'b1;
                        else mins_q[15:12] <= '0;   // 9999 rolls to 0000
                    end
                end
            end
        end
    end

    assign elapsed.secs     = secs_q;
    assign elapsed.mins_bcd = mins_q;

endmodule

// File: source/mem_test_macros.svh
`ifndef MEM_TEST_MACROS_SVH
`define MEM_TEST_MACROS_SVH

// Test RAM geometry
`define MEM_ADDR_BITS   8
`define MEM_DATA_BITS   16
`define MEM_WORDS       (1 << `MEM_ADDR_BITS)

// Timebase, scaled down for simulation
`define TICKS_PER_SEC   50     // clk_gui cycles per second
`define SECS_PER_MIN    60

////////////////////////////////////////////////////////////////////////////
// AXI4-Lite register offsets
////////////////////////////////////////////////////////////////////////////

`define REG_CTRL        4'h0   // run, clear pulse, fault mask
`define REG_PASS        4'h4   // Completed passes
`define REG_FAIL        4'h8   // Mismatching words
`define REG_ELAPSED     4'hC   // secs and BCD minutes

`endif

// File: source/mem_test_pkg.sv
`include "mem_test_macros.svh"

package mem_test_pkg;

    // Manager side of the register bus
    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    // Slave side of the register bus
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;    // Always OKAY
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;    // Always OKAY
    } axil_rsp_t;

    // One access to the test RAM
    typedef struct packed {
        logic                      we;
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic [`MEM_DATA_BITS-1:0] wdata;
    } mem_req_t;

    // Running results
    typedef struct packed {
        logic [31:0] passcount;
        logic [31:0] failcount;
    } test_stat_t;

    // Same layout as REG_ELAPSED
    typedef struct packed {
        logic [15:0] secs;       // Binary
        logic [15:0] mins_bcd;   // Four BCD digits
    } elapsed_t;

    typedef struct packed {
        logic                      run;
        logic                      clear;        // One-cycle pulse
        logic [`MEM_DATA_BITS-1:0] fault_mask;   // Stuck-at-one bits
    } tester_ctrl_t;

endpackage

// File: source/mem_test_top.sv
`timescale 1ns/1ps
`include "mem_test_macros.svh"

module mem_test_top (
    input  logic                    clk_gui,
    input  logic                    timer_reset,
    input  mem_test_pkg::axil_req_t axil_req,
    output mem_test_pkg::axil_rsp_t axil_rsp
);

    mem_test_pkg::tester_ctrl_t ctrl;       // Host controls
    mem_test_pkg::mem_req_t     mem_req;    // Tester to RAM
    mem_test_pkg::test_stat_t   stat;       // Pass and fail counts
    mem_test_pkg::elapsed_t     elapsed;    // Soak time
    logic [`MEM_DATA_BITS-1:0]  ram_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Tester and its memory
    ////////////////////////////////////////////////////////////////////////////

    mem_tester tester_i (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .ctrl        (ctrl),
        .mem_req     (mem_req),
        .rdata       (ram_rdata),
        .stat        (stat)
    );

    test_ram ram_i (
        .clk_gui    (clk_gui),
        .mem_req    (mem_req),
        .fault_mask (ctrl.fault_mask),  // Injected stuck-at-one bits
        .rdata      (ram_rdata)
    );

    // Time since reset
    elapsed_timer timer_i (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .elapsed     (elapsed)
    );

    // Host access
    status_regs_axil regs_i (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .ctrl        (ctrl),
        .stat        (stat),
        .elapsed     (elapsed)
    );

endmodule

// File: source/mem_tester.sv
`timescale 1ns/1ps
`include "mem_test_macros.svh"

module mem_tester (
    input  logic                       clk_gui,
    input  logic                       timer_reset,
    input  mem_test_pkg::tester_ctrl_t ctrl,
    output mem_test_pkg::mem_req_t     mem_req,
    input  logic [`MEM_DATA_BITS-1:0]  rdata,
    output mem_test_pkg::test_stat_t   stat
);

    localparam logic [`MEM_ADDR_BITS-1:0] ADDR_LAST = {`MEM_ADDR_BITS{1'b1}};

    typedef enum logic [1:0] {
        PH_IDLE,     // Waiting for run
        PH_WRITE,    // Pattern fill sweep
        PH_READ      // Read back sweep
    } phase_t;

    phase_t                    phase_q;
    logic [`MEM_ADDR_BITS-1:0] addr_q;
    logic [7:0]                pass_q;      // Low byte of pass number

    // Compare stage, one cycle behind the read
    logic                      chk_valid_q;
    logic                      chk_last_q;
    logic [`MEM_DATA_BITS-1:0] chk_exp_q;

    mem_test_pkg::test_stat_t  stat_q;

    // High byte mixes in the pass, low byte is the address
    function automatic logic [`MEM_DATA_BITS-1:0] pattern(
        input logic [`MEM_ADDR_BITS-1:0] addr,
        input logic [7:0]                pass
    );
        return {addr ^ pass, addr};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Sweep sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset || ctrl.clear) begin
            phase_q <= PH_IDLE;     // Back to pass 0, address 0
            addr_q  <= '0;
            pass_q  <= '0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (ctrl.run)
                        phase_q <= PH_WRITE;
                end
                PH_WRITE: begin
                    addr_q <= addr_q + 1'b1;            // Wraps to 0 for the read sweep
                    if (addr_q == ADDR_LAST)
                        phase_q <= PH_READ;
                end
                PH_READ: begin
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == ADDR_LAST) begin
                        pass_q  <= pass_q + 1'b1;
                        // run is only sampled between passes
                        phase_q <= ctrl.run ? PH_WRITE : PH_IDLE;
                    end
                end
                default: phase_q <= PH_IDLE;
            endcase
        end
    end

    // RAM request straight from sequencer state
    assign mem_req.we    = (phase_q == PH_WRITE);
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = pattern(addr_q, pass_q);

    ////////////////////////////////////////////////////////////////////////////
    // Compare and count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset || ctrl.clear) begin
            chk_valid_q <= 1'b0;    // Drop any read in flight
            chk_last_q  <= 1'b0;
        end else begin
            chk_valid_q <= (phase_q == PH_READ);
            chk_last_q  <= (phase_q == PH_READ) && (addr_q == ADDR_LAST);
        end
    end

    // Expected word tracks the issued read
    always_ff @(posedge clk_gui) begin
        chk_exp_q <= pattern(addr_q, pass_q);
    end

    always_ff @(posedge clk_gui) begin
        if (timer_reset || ctrl.clear) begin
            stat_q <= '0;
        end else if (chk_valid_q) begin
            if (rdata != chk_exp_q)
                stat_q.failcount <= stat_q.failcount + 1'b1;   // One per bad word
            if (chk_last_q)
                stat_q.passcount <= stat_q.passcount + 1'b1;   // Counted with or without fails
        end
    end

    assign stat = stat_q;

endmodule

// File: source/status_regs_axil.sv
`timescale 1ns/1ps
`include "mem_test_macros.svh"

module status_regs_axil (
    input  logic                       clk_gui,
    input  logic                       timer_reset,
    input  mem_test_pkg::axil_req_t    axil_req,
    output mem_test_pkg::axil_rsp_t    axil_rsp,
    output mem_test_pkg::tester_ctrl_t ctrl,
    input  mem_test_pkg::test_stat_t   stat,
    input  mem_test_pkg::elapsed_t     elapsed
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Write channel state
    logic        aw_held_q;
    logic [3:0]  aw_addr_q;
    logic        w_held_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic        bvalid_q;
    logic        aw_ready;
    logic        w_ready;
    logic        aw_fire;
    logic        w_fire;
    logic        wr_commit;     // Both halves present

    // Read channel state
    logic        ar_held_q;
    logic [3:0]  ar_addr_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_mux;
    logic        ar_ready;
    logic        ar_fire;

    mem_test_pkg::tester_ctrl_t ctrl_q;

    // Closed while a half is held or the response waits
    assign aw_ready  = ~aw_held_q & ~bvalid_q;
    assign w_ready   = ~w_held_q & ~bvalid_q;
    assign ar_ready  = ~ar_held_q & ~rvalid_q;
    assign aw_fire   = axil_req.awvalid & aw_ready;
    assign w_fire    = axil_req.wvalid & w_ready;
    assign ar_fire   = axil_req.arvalid & ar_ready;
    assign wr_commit = aw_held_q & w_held_q;

    ////////////////////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            if (aw_fire) aw_held_q <= 1'b1;
            else if (wr_commit) aw_held_q <= 1'b0;
            if (w_fire) w_held_q <= 1'b1;
            else if (wr_commit) w_held_q <= 1'b0;
            if (wr_commit) bvalid_q <= 1'b1;                    // Two cycles after accept
            else if (bvalid_q && axil_req.bready) bvalid_q <= 1'b0;
        end
    end

    // Address and data latch independently
    always_ff @(posedge clk_gui) begin
        if (aw_fire)
            aw_addr_q <= axil_req.awaddr;
        if (w_fire) begin
            w_data_q <= axil_req.wdata;
            w_strb_q <= axil_req.wstrb;
        end
    end

    // Control register, other offsets ignore writes
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q.clear <= 1'b0;                               // Pulse lasts one cycle
            if (wr_commit && aw_addr_q == `REG_CTRL) begin
                if (w_strb_q[0]) begin
                    ctrl_q.run   <= w_data_q[0];
                    ctrl_q.clear <= w_data_q[1];
                end
                if (w_strb_q[2]) ctrl_q.fault_mask[7:0]  <= w_data_q[23:16];
                if (w_strb_q[3]) ctrl_q.fault_mask[15:8] <= w_data_q[31:24];
            end
        end
    end

    assign ctrl = ctrl_q;

    ////////////////////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ar_addr_q)
            `REG_CTRL:    rd_mux = {ctrl_q.fault_mask, 14'd0, 1'b0, ctrl_q.run};  // clear reads 0
            `REG_PASS:    rd_mux = stat.passcount;
            `REG_FAIL:    rd_mux = stat.failcount;
            `REG_ELAPSED: rd_mux = elapsed;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            ar_held_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (ar_fire) ar_held_q <= 1'b1;
            else if (ar_held_q) ar_held_q <= 1'b0;
            if (ar_held_q) rvalid_q <= 1'b1;                   // Held until rready
            else if (rvalid_q && axil_req.rready) rvalid_q <= 1'b0;
        end
    end

    // Sampled once, stable under back-pressure
    always_ff @(posedge clk_gui) begin
        if (ar_fire)
            ar_addr_q <= axil_req.araddr;
        if (ar_held_q)
            rdata_q <= rd_mux;
    end

    always_comb begin
        axil_rsp.awready = aw_ready;
        axil_rsp.wready  = w_ready;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = RESP_OKAY;
        axil_rsp.arready = ar_ready;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = RESP_OKAY;
    end

endmodule

// File: source/test_ram.sv
`timescale 1ns/1ps
`include "mem_test_macros.svh"

module test_ram (
    input  logic                      clk_gui,
    input  mem_test_pkg::mem_req_t    mem_req,
    input  logic [`MEM_DATA_BITS-1:0] fault_mask,
    output logic [`MEM_DATA_BITS-1:0] rdata
);

    // Storage array
    logic [`MEM_DATA_BITS-1:0] mem [`MEM_WORDS];

    // Raw word from the last read
    logic [`MEM_DATA_BITS-1:0] rd_word_q;

    ////////////////////////////////////////////////////////////////////////////
    // Write port and registered read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (mem_req.we)
            mem[mem_req.addr] <= mem_req.wdata;   // Lands on this edge
    end

    // Old data on a same-address write, never used by the tester
    always_ff @(posedge clk_gui) begin
        rd_word_q <= mem[mem_req.addr];           // One cycle latency
    end

    // Faulty device model
    // Masked bits read back as one regardless of contents
    assign rdata = rd_word_q | fault_mask;

endmodule

// File: test/mem_test_properties.sv
`timescale 1ns/1ps

module mem_test_properties (
    input logic                    clk_gui,
    input logic                    timer_reset,
    input mem_test_pkg::axil_req_t axil_req,
    input mem_test_pkg::axil_rsp_t axil_rsp
);

    // Responses held under back-pressure
    assert property (@(posedge clk_gui) disable iff (timer_reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk_gui) disable iff (timer_reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid or rdata changed before rready");

    // Two cycles from accept to response at the earliest
    assert property (@(posedge clk_gui) disable iff (timer_reset)
        axil_req.arvalid && axil_rsp.arready |=> !axil_rsp.rvalid)
        else $error("read response one cycle after the address was taken");

    assert property (@(posedge clk_gui) disable iff (timer_reset)
        axil_req.awvalid && axil_rsp.awready && axil_req.wvalid && axil_rsp.wready
        |=> !axil_rsp.bvalid)
        else $error("write response one cycle after both channels were taken");

endmodule

// File: test/mem_test_stim.txt
# op offset value, offset and value in hex
# read compares, wait polls REG_PASS, delay idles cycles, time checks REG_ELAPSED
read 0 0
read 4 0
read 8 0
time 0 0
write 0 1
wait 4 3
write 0 0
read 8 0
write 0 01000002
read 4 0
read 8 0
write 0 01000001
wait 4 1
write 0 01000000
wait 4 2
read 4 2
read 8 100
read 0 01000000
write 4 ffffffff
read 4 2
write 8 0
read 8 100
delay 0 bb8
time 0 0

// File: test/mem_test_tb.sv
`timescale 1ns/1ps
`include "mem_test_macros.svh"

module mem_test_tb;

    logic                    clk_gui;
    logic                    timer_reset;
    mem_test_pkg::axil_req_t req;
    mem_test_pkg::axil_rsp_t rsp;
    logic [31:0]             lfsr_q = 32'h612;   // Fixed seed
    longint                  cycles = 0;          // Cycles since reset fell
    string                   op_q[$];
    logic [3:0]              off_q[$];
    logic [31:0]             val_q[$];
    bit                      loaded;              // Stimulus in memory, bound known
    longint                  bound;

    tb_clock_gen clk_i (.clk_gui(clk_gui), .timer_reset(timer_reset));

    mem_test_top dut_i (.clk_gui(clk_gui), .timer_reset(timer_reset), .axil_req(req),
                        .axil_rsp(rsp));

    bind status_regs_axil mem_test_properties props_i (.clk_gui(clk_gui),
        .timer_reset(timer_reset), .axil_req(axil_req), .axil_rsp(axil_rsp));

    always @(posedge clk_gui) cycles <= timer_reset ? 0 : cycles + 1;

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic reg_write(input logic [3:0] off, input logic [31:0] val);
        bit aw_done;
        bit w_done;
        aw_done = 0;
        w_done  = 0;
        repeat (take_bits(2)) @(posedge clk_gui);           // Idle gap
        req.awvalid <= 1'b1;
        req.awaddr  <= off;
        req.wvalid  <= 1'b1;
        req.wdata   <= val;
        req.wstrb   <= 4'hF;
        while (!(aw_done && w_done)) begin
            @(posedge clk_gui);
            if (req.awvalid && rsp.awready) begin
                aw_done = 1;
                req.awvalid <= 1'b0;
            end
            if (req.wvalid && rsp.wready) begin
                w_done = 1;
                req.wvalid <= 1'b0;
            end
        end
        repeat (take_bits(3)) @(posedge clk_gui);           // bready delay
        req.bready <= 1'b1;
        do @(posedge clk_gui); while (!(rsp.bvalid && req.bready));
        assert (rsp.bresp == 2'b00)
            else stop_on_failure($sformatf("error t=%0t bresp got %b expected %b",
                                           $time, rsp.bresp, 2'b00));
        req.bready <= 1'b0;
        @(posedge clk_gui);
        assert (!rsp.bvalid) else stop_on_failure("write response seen twice");
    endtask

    task automatic reg_read(input logic [3:0] off, output logic [31:0] val);
        repeat (take_bits(2)) @(posedge clk_gui);
        req.arvalid <= 1'b1;
        req.araddr  <= off;
        do @(posedge clk_gui); while (!rsp.arready);
        req.arvalid <= 1'b0;
        repeat (take_bits(3)) @(posedge clk_gui);           // rready delay
        req.rready <= 1'b1;
        do @(posedge clk_gui); while (!(rsp.rvalid && req.rready));
        val = rsp.rdata;
        assert (rsp.rresp == 2'b00)
            else stop_on_failure($sformatf("error t=%0t rresp got %b expected %b",
                                           $time, rsp.rresp, 2'b00));
        req.rready <= 1'b0;
        @(posedge clk_gui);
        assert (!rsp.rvalid) else stop_on_failure("read response seen twice");
    endtask

    task automatic read_and_compare(input logic [3:0] off, input logic [31:0] exp);
        logic [31:0] got;
        reg_read(off, got);
        assert (got == exp)
            else stop_on_failure($sformatf("error t=%0t rdata at %h got %h expected %h",
                                           $time, off, got, exp));
    endtask

    // Minutes as four BCD digits
    function automatic logic [15:0] to_bcd(input int mins);
        logic [15:0] d;
        for (int i = 0; i < 4; i++) begin
            d[i*4 +: 4] = 4'(mins % 10);
            mins = mins / 10;
        end
        return d;
    endfunction

    // Reading must match the timer at some cycle inside the read window
    task automatic check_elapsed();
        logic [31:0] v;
        longint      secs_lo;
        longint      secs_hi;
        logic [31:0] exp_lo;
        logic [31:0] exp_hi;
        secs_lo = cycles / `TICKS_PER_SEC;                  // Before the address goes out
        reg_read(`REG_ELAPSED, v);
        secs_hi = cycles / `TICKS_PER_SEC;                  // After the response
        exp_lo  = {16'(secs_lo), to_bcd(int'(secs_lo / `SECS_PER_MIN))};
        exp_hi  = {16'(secs_hi), to_bcd(int'(secs_hi / `SECS_PER_MIN))};
        assert (v == exp_lo || v == exp_hi)
            else stop_on_failure($sformatf("error t=%0t elapsed got %h expected %h or %h",
                                           $time, v, exp_lo, exp_hi));
    endtask

    // Watchdog, worst case of four passes per line plus idle time
    initial begin
        wait (loaded);
        #(bound * 20);
        stop_on_failure("watchdog expired before the stimulus finished");
    end

    initial begin
        int          fd;
        string       line;
        string       op;
        logic [3:0]  off;
        logic [31:0] val;
        logic [31:0] got;
        req    = '0;
        bound  = 1000;
        fd = $fopen("test/mem_test_stim.txt", "r");
        if (fd == 0) stop_on_failure("cannot open the stimulus file");
        while ($fgets(line, fd)) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%s %h %h", op, off, val) == 3) begin
                op_q.push_back(op);
                off_q.push_back(off);
                val_q.push_back(val);
                bound += (op == "delay") ? val : 4 * (2 * `MEM_WORDS + 1);
            end
        end
        $fclose(fd);
        loaded = 1'b1;
        @(negedge timer_reset);
        foreach (op_q[i]) begin
            case (op_q[i])
                "write": reg_write(off_q[i], val_q[i]);
                "read": read_and_compare(off_q[i], val_q[i]);
                "wait": begin
                    do reg_read(`REG_PASS, got); while (got < val_q[i]);   // Poll passcount
                end
                "delay": repeat (val_q[i]) @(posedge clk_gui);
                "time": check_elapsed();
                default: stop_on_failure($sformatf("unknown stimulus operation %s", op_q[i]));
            endcase
        end
        // Clear again over a nonzero fail count, run set this time
        reg_write(`REG_CTRL, 32'h0000_0003);
        read_and_compare(`REG_CTRL, 32'h0000_0001);         // clear bit reads 0
        read_and_compare(`REG_PASS, 32'h0);
        read_and_compare(`REG_FAIL, 32'h0);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_gui,
    output logic timer_reset
);

    initial begin
        clk_gui     = 1'b0;
        timer_reset = 1'b1;         // Held for two rising edges
        repeat (2) @(posedge clk_gui);
        timer_reset <= 1'b0;
    end

    always #10 clk_gui = ~clk_gui;  // 20 ns period

endmodule
